// File: list.f
design/sd_data_pkg.sv
design/sd_crc16.sv
design/sd_dat_tx.sv
design/sd_dat_rx.sv
design/sd_data_ctrl.sv
design/sd_data_engine.sv
dv/sd_data_checker.sv
dv/tb_sd_data_engine.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SD DAT engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_sd_data_engine -f list.f -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
    exit 0
else
    exit 1
fi

// File: dv/tb_sd_data_engine.sv
// SD DAT engine testbench
// Clock, reset, card model and stimulus for writes, reads, timeout and start gating
module tb_sd_data_engine;
    timeunit 1ns;
    timeprecision 1ps;
    import sd_data_pkg::*;

    logic   pclk;
    logic   presetn;
    logic   start, write, clk_enable, security_lock, access_granted;
    word_t  wr_data;
    dat_t   dat_in;
    dat_t   dat_out;
    logic   dat_oe, busy, done, crc_err, timeout;
    word_t  rd_data;
    crc16_t crc;
    // Checker expectations
    logic   arm, exp_write, exp_done, exp_crc_err, exp_timeout;
    int     exp_busy;
    word_t  exp_word;
    crc16_t exp_crc;
    int     tests, fails, errors;
    int     hangs = 0;
    logic [31:0] rng_state = 32'd92818;
    int     n_writes = 4;
    int     n_reads  = 6;     // Four good reads then two with a flipped CRC bit

    sd_data_engine DUT (
        .PCLK_i(pclk), .PRESETn_i(presetn), .start_i(start), .write_i(write),
        .wr_data_i(wr_data), .clk_enable_i(clk_enable), .security_lock_i(security_lock),
        .access_granted_i(access_granted), .dat_i(dat_in), .dat_o(dat_out),
        .dat_oe_o(dat_oe), .busy_o(busy), .done_o(done), .crc_err_o(crc_err),
        .timeout_o(timeout), .rd_data_o(rd_data), .crc_o(crc)
    );

    sd_data_checker u_checker (
        .PCLK_i(pclk), .PRESETn_i(presetn), .arm_i(arm), .exp_write_i(exp_write),
        .exp_done_i(exp_done), .exp_crc_err_i(exp_crc_err), .exp_timeout_i(exp_timeout),
        .exp_busy_i(exp_busy), .exp_word_i(exp_word), .exp_crc_i(exp_crc),
        .dut_dat_i(dat_out), .dut_oe_i(dat_oe), .busy_i(busy), .done_i(done),
        .crc_err_i(crc_err), .timeout_i(timeout), .rd_data_i(rd_data), .crc_i(crc),
        .tests_o(tests), .fails_o(fails), .errors_o(errors)
    );

    initial begin
        pclk = 1'b0;
        forever #4 pclk = ~pclk;
    end

    // ==========================================================
    // Reference model and helpers
    // ==========================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Remainder of word * x^16 divided by x^16 + x^12 + x^5 + 1
    function automatic crc16_t crc16_of_word(input word_t w);
        logic [47:0] m;
        m = {w, 16'h0000};
        for (int i = 47; i >= 16; i--) begin
            if (m[i]) m[i -: 17] = m[i -: 17] ^ 17'h11021;
        end
        return m[15:0];
    endfunction

    task automatic next_cycle();
        @(posedge pclk);
        #1;
    endtask

    task automatic arm_checks(input logic wr, input logic dn, input logic ce, input logic to,
                              input int bsy, input word_t w, input crc16_t c);
        {exp_write, exp_done, exp_crc_err, exp_timeout} = {wr, dn, ce, to};
        exp_busy = bsy;
        exp_word = w;
        exp_crc  = c;
        arm      = 1'b1;
    endtask

    task automatic close_checks();
        repeat (3) next_cycle();
        arm = 1'b0;
        repeat (2) next_cycle();
    endtask

    task automatic issue_start(input logic wr, input word_t w);
        start   = 1'b1;
        write   = wr;
        wr_data = w;
        next_cycle();
        start   = 1'b0;
    endtask

    task automatic wait_result(input int limit);
        int n;
        n = 0;
        while (!(done || crc_err || timeout) && n < limit) begin
            next_cycle();
            n++;
        end
        if (n >= limit) begin
            $display("no result pulse from the DUT within %0d cycles", limit);
            hangs++;
        end
    endtask

    // Card side of a read with idle, start nibble, word, CRC on DAT0 and idle again
    task automatic card_reply(input word_t w, input crc16_t c, input int lead);
        repeat (lead) next_cycle();
        dat_in = 4'h0;
        next_cycle();
        for (int i = NIBBLES_PER_WORD - 1; i >= 0; i--) begin
            dat_in = w[4 * i +: 4];
            next_cycle();
        end
        for (int i = CRC_BITS - 1; i >= 0; i--) begin
            dat_in = {3'b111, c[i]};
            next_cycle();
        end
        dat_in = DAT_IDLE;
    endtask

    task automatic gated_start(input logic lock, input logic grant, input logic clk_en);
        security_lock  = lock;
        access_granted = grant;
        clk_enable     = clk_en;
        rng_state      = xorshift32(rng_state);
        arm_checks(1'b0, 1'b0, 1'b0, 1'b0, 0, '0, '0);
        issue_start(1'b1, rng_state);
        repeat (10) next_cycle();
        close_checks();
        {security_lock, access_granted, clk_enable} = 3'b011;
    endtask

    // ==========================================================
    // Stimulus
    // ==========================================================
    initial begin
        word_t  w;
        crc16_t c;
        int     lead;
        {start, write, wr_data, arm, presetn} = '0;
        {clk_enable, security_lock, access_granted} = 3'b101;
        dat_in = DAT_IDLE;
        repeat (3) @(posedge pclk);
        #1 presetn = 1'b1;
        next_cycle();

        for (int t = 0; t < n_writes; t++) begin
            rng_state = xorshift32(rng_state);
            w = rng_state;
            arm_checks(1'b1, 1'b1, 1'b0, 1'b0, 26, w, crc16_of_word(w));
            issue_start(1'b1, w);
            if (t == 1) begin
                repeat (5) next_cycle();
                issue_start(1'b0, ~w);        // Must be ignored while busy
            end
            wait_result(40);
            close_checks();
        end

        for (int t = 0; t < n_reads; t++) begin
            rng_state = xorshift32(rng_state);
            w = rng_state;
            rng_state = xorshift32(rng_state);
            lead = int'(rng_state % 32'd6);
            c = crc16_of_word(w);
            if (t >= 4) begin
                c = c ^ (16'h0001 << (rng_state[11:8]));
            end
            arm_checks(1'b0, t < 4, t >= 4, 1'b0, lead + 26, w, c);
            issue_start(1'b0, '0);
            card_reply(w, c, lead);
            wait_result(8);
            close_checks();
        end

        // Card never answers
        arm_checks(1'b0, 1'b0, 1'b0, 1'b1, TIMEOUT_LIMIT, '0, '0);
        issue_start(1'b0, '0);
        wait_result(TIMEOUT_LIMIT + 8);
        close_checks();

        gated_start(1'b1, 1'b1, 1'b1);
        gated_start(1'b0, 1'b0, 1'b1);
        gated_start(1'b0, 1'b1, 1'b0);

        $display("%0d tests, %0d failed, %0d errors, %0d hangs", tests, fails, errors, hangs);
        if (fails == 0 && errors == 0 && hangs == 0 && tests == n_writes + n_reads + 4) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Watchdog sized from the test lengths plus margin
    initial begin
        repeat (n_writes * 45 + n_reads * 45 + TIMEOUT_LIMIT + 3 * 20 + 200) @(posedge pclk);
        $display("simulation did not finish in the expected time");
        $display("test failed");
        $finish;
    end

endmodule

// File: dv/sd_data_checker.sv
// SD DAT engine checker
// Watches the DUT ports during each armed test window and compares with expectations
module sd_data_checker (
    input  logic                PCLK_i,
    input  logic                PRESETn_i,
    input  logic                arm_i,
    input  logic                exp_write_i,
    input  logic                exp_done_i,
    input  logic                exp_crc_err_i,
    input  logic                exp_timeout_i,
    input  int                  exp_busy_i,
    input  sd_data_pkg::word_t  exp_word_i,
    input  sd_data_pkg::crc16_t exp_crc_i,
    input  sd_data_pkg::dat_t   dut_dat_i,
    input  logic                dut_oe_i,
    input  logic                busy_i,
    input  logic                done_i,
    input  logic                crc_err_i,
    input  logic                timeout_i,
    input  sd_data_pkg::word_t  rd_data_i,
    input  sd_data_pkg::crc16_t crc_i,
    output int                  tests_o,
    output int                  fails_o,
    output int                  errors_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import sd_data_pkg::*;

    int     n_beats;       // Cycles with the bus driven
    int     n_done;
    int     n_err;
    int     n_tmo;
    int     n_busy;
    int     cyc;
    int     last_oe_cyc;
    int     done_cyc;
    int     test_errs;
    logic   armed_q;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %0t %s exp=%0h act=%0h", $time, name, exp, act);
            test_errs++;
        end
    endtask

    // Bus beat k of a write in the order start, data, CRC on DAT0, end
    function automatic dat_t expected_nibble(input int k);
        if (k == 0) begin
            return 4'h0;
        end else if (k <= NIBBLES_PER_WORD) begin
            return exp_word_i[4 * (NIBBLES_PER_WORD - k) +: 4];
        end else if (k <= NIBBLES_PER_WORD + CRC_BITS) begin
            return {3'b111, exp_crc_i[CRC_BITS - 1 - (k - NIBBLES_PER_WORD - 1)]};
        end
        return DAT_IDLE;
    endfunction

    // ==========================================================
    // Window bookkeeping
    // ==========================================================
    task automatic collect_sample();
        int beats;
        beats = 2 + NIBBLES_PER_WORD + CRC_BITS;
        cyc++;
        if (dut_oe_i) begin
            if (exp_write_i && n_beats < beats) begin
                check_value($sformatf("dat_o beat %0d", n_beats),
                            32'(expected_nibble(n_beats)), 32'(dut_dat_i));
            end
            n_beats++;
            last_oe_cyc = cyc;
        end
        if (busy_i) n_busy++;
        if (done_i) begin
            n_done++;
            done_cyc = cyc;
            if (exp_done_i && !exp_write_i) check_value("rd_data_o", exp_word_i, rd_data_i);
        end
        if (crc_err_i) n_err++;
        if (timeout_i) n_tmo++;
        if ((done_i || crc_err_i) && (exp_done_i || exp_crc_err_i)) begin
            check_value("crc_o", 32'(exp_crc_i), 32'(crc_i));
        end
        if ((done_i || crc_err_i || timeout_i) && busy_i) begin
            $display("busy_o was still high when the result pulse came");
            test_errs++;
        end
    endtask

    task automatic evaluate_window();
        int beats;
        beats = 2 + NIBBLES_PER_WORD + CRC_BITS;
        check_value("done_o pulses", 32'(exp_done_i), n_done);
        check_value("crc_err_o pulses", 32'(exp_crc_err_i), n_err);
        check_value("timeout_o pulses", 32'(exp_timeout_i), n_tmo);
        check_value("busy_o cycles", exp_busy_i, n_busy);
        if (exp_write_i) begin
            check_value("dat_oe_o cycles", beats, n_beats);
            if (done_cyc != last_oe_cyc + 1) begin
                $display("done_o did not pulse in the cycle after the end nibble");
                test_errs++;
            end
        end else begin
            check_value("dat_oe_o cycles", 0, n_beats);
        end

        tests_o++;
        errors_o += test_errs;
        if (test_errs == 0) begin
            $display("test %0d: ok", tests_o);
        end else begin
            fails_o++;
            $display("test %0d: %0d errors", tests_o, test_errs);
        end
    endtask

    // Sampled mid cycle away from the DUT's clock edge
    always @(negedge PCLK_i) begin
        if (!PRESETn_i) begin
            armed_q  = 1'b0;
            tests_o  = 0;
            fails_o  = 0;
            errors_o = 0;
        end else begin
            if (arm_i && !armed_q) begin
                {n_beats, n_done, n_err, n_tmo, n_busy, cyc} = '0;
                last_oe_cyc = -1;
                done_cyc    = -1;
                test_errs   = 0;
            end
            if (arm_i) collect_sample();
            if (!arm_i && armed_q) evaluate_window();
            armed_q = arm_i;
        end
    end

endmodule

// File: design/sd_data_engine.sv
// SD DAT engine top level
// Connects the transfer controller, CRC unit and the transmit and receive paths
module sd_data_engine (
    input  logic                PCLK_i,
    input  logic                PRESETn_i,
    input  logic                start_i,
    input  logic                write_i,
    input  sd_data_pkg::word_t  wr_data_i,
    input  logic                clk_enable_i,
    input  logic                security_lock_i,
    input  logic                access_granted_i,
    input  sd_data_pkg::dat_t   dat_i,
    output sd_data_pkg::dat_t   dat_o,
    output logic                dat_oe_o,
    output logic                busy_o,
    output logic                done_o,
    output logic                crc_err_o,
    output logic                timeout_o,
    output sd_data_pkg::word_t  rd_data_o,
    output sd_data_pkg::crc16_t crc_o
);
    import sd_data_pkg::*;

    crc16_t      crc;
    crc16_t      rx_crc;
    word_t       rx_word;
    dat_t        tx_nibble;
    dat_t        crc_nibble;
    data_state_t phase;
    logic        start_seen;
    logic        crc_clear;
    logic        crc_en;
    logic        tx_load;
    logic        tx_shift;
    logic        rx_data_en;
    logic        rx_crc_en;

    // CRC input is the incoming bus on reads, the next tx nibble otherwise
    assign crc_nibble = rx_data_en ? dat_i : tx_nibble;

    sd_data_ctrl u_ctrl (
        .PCLK_i           (PCLK_i),
        .PRESETn_i        (PRESETn_i),
        .start_i          (start_i),
        .write_i          (write_i),
        .clk_enable_i     (clk_enable_i),
        .security_lock_i  (security_lock_i),
        .access_granted_i (access_granted_i),
        .start_seen_i     (start_seen),
        .crc_i            (crc),
        .rx_crc_i         (rx_crc),
        .rx_word_i        (rx_word),
        .crc_clear_o      (crc_clear),
        .crc_en_o         (crc_en),
        .tx_load_o        (tx_load),
        .tx_shift_o       (tx_shift),
        .phase_o          (phase),
        .rx_data_en_o     (rx_data_en),
        .rx_crc_en_o      (rx_crc_en),
        .busy_o           (busy_o),
        .done_o           (done_o),
        .crc_err_o        (crc_err_o),
        .timeout_o        (timeout_o),
        .rd_data_o        (rd_data_o),
        .crc_o            (crc_o)
    );

    sd_crc16 u_crc (
        .PCLK_i    (PCLK_i),
        .PRESETn_i (PRESETn_i),
        .clear_i   (crc_clear),
        .enable_i  (crc_en),
        .nibble_i  (crc_nibble),
        .crc_o     (crc)
    );

    sd_dat_tx u_tx (
        .PCLK_i    (PCLK_i),
        .PRESETn_i (PRESETn_i),
        .load_i    (tx_load),
        .word_i    (wr_data_i),
        .crc_i     (crc),
        .phase_i   (phase),
        .shift_i   (tx_shift),
        .nibble_o  (tx_nibble),
        .dat_o     (dat_o),
        .dat_oe_o  (dat_oe_o)
    );

    sd_dat_rx u_rx (
        .PCLK_i       (PCLK_i),
        .PRESETn_i    (PRESETn_i),
        .dat_i        (dat_i),
        .data_en_i    (rx_data_en),
        .crc_en_i     (rx_crc_en),
        .start_seen_o (start_seen),
        .word_o       (rx_word),
        .rx_crc_o     (rx_crc)
    );

endmodule

// File: design/sd_data_ctrl.sv
// SD DAT transfer controller
// Sequences write and read phases, gates the start, watches the timeout
// and issues one result pulse per transfer
module sd_data_ctrl (
    input  logic                     PCLK_i,
    input  logic                     PRESETn_i,
    input  logic                     start_i,
    input  logic                     write_i,
    input  logic                     clk_enable_i,
    input  logic                     security_lock_i,
    input  logic                     access_granted_i,
    input  logic                     start_seen_i,
    input  sd_data_pkg::crc16_t      crc_i,
    input  sd_data_pkg::crc16_t      rx_crc_i,
    input  sd_data_pkg::word_t       rx_word_i,
    output logic                     crc_clear_o,
    output logic                     crc_en_o,
    output logic                     tx_load_o,
    output logic                     tx_shift_o,
    output sd_data_pkg::data_state_t phase_o,
    output logic                     rx_data_en_o,
    output logic                     rx_crc_en_o,
    output logic                     busy_o,
    output logic                     done_o,
    output logic                     crc_err_o,
    output logic                     timeout_o,
    output sd_data_pkg::word_t       rd_data_o,
    output sd_data_pkg::crc16_t      crc_o
);
    import sd_data_pkg::*;

    data_state_t          state_q;
    data_state_t          state_d;
    phase_cnt_t           cnt_q;        // Position within the current phase
    logic [TIMEOUT_W-1:0] tmo_q;        // Cycles spent waiting for start
    logic                 accept;
    logic                 last_nibble;
    logic                 last_crc_bit;
    logic                 tmo_hit;
    logic                 crc_match;

    // Start only when idle and the card may be accessed
    assign accept = (state_q == IDLE) && start_i && clk_enable_i
                    && !security_lock_i && access_granted_i;

    assign last_nibble  = (cnt_q == phase_cnt_t'(NIBBLES_PER_WORD - 1));
    assign last_crc_bit = (cnt_q == phase_cnt_t'(CRC_BITS - 1));
    assign tmo_hit      = (tmo_q == TIMEOUT_W'(TIMEOUT_LIMIT - 1));
    assign crc_match    = (crc_i == rx_crc_i);

    // ==========================================================
    // Next state
    // ==========================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = write_i ? TX_START : RX_WAIT;
                end
            end
            TX_START: state_d = TX_DATA;
            TX_DATA:  state_d = last_nibble ? TX_CRC : TX_DATA;
            TX_CRC:   state_d = last_crc_bit ? TX_END : TX_CRC;
            TX_END:   state_d = IDLE;
            RX_WAIT: begin
                if (start_seen_i) begin
                    state_d = RX_DATA;
                end else if (tmo_hit) begin
                    state_d = IDLE;                 // Give up on the card
                end
            end
            RX_DATA:  state_d = last_nibble ? RX_CRC : RX_DATA;
            RX_CRC:   state_d = last_crc_bit ? RX_CHECK : RX_CRC;
            RX_CHECK: state_d = IDLE;
            default:  state_d = IDLE;
        endcase
    end

    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            tmo_q   <= '0;
        end else begin
            state_q <= state_d;
            if ((state_d != state_q) || (state_q == IDLE)) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            tmo_q <= (state_q == RX_WAIT) ? tmo_q + 1'b1 : '0;
        end
    end

    // ==========================================================
    // Datapath controls
    // ==========================================================
    // The transmit register follows the next state, so the bus
    // lines up with the state register
    assign phase_o      = state_d;
    assign tx_load_o    = accept && write_i;
    assign tx_shift_o   = (state_d == TX_DATA) || (state_d == TX_CRC);
    assign rx_data_en_o = (state_q == RX_DATA);
    assign rx_crc_en_o  = (state_q == RX_CRC);
    assign crc_clear_o  = accept;
    assign crc_en_o     = (state_d == TX_DATA) || (state_q == RX_DATA);
    assign busy_o       = (state_q != IDLE);

    // Result pulses and held results
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            done_o    <= 1'b0;
            crc_err_o <= 1'b0;
            timeout_o <= 1'b0;
            rd_data_o <= '0;
            crc_o     <= '0;
        end else begin
            done_o    <= 1'b0;
            crc_err_o <= 1'b0;
            timeout_o <= 1'b0;
            case (state_q)
                TX_END: begin
                    done_o <= 1'b1;
                    crc_o  <= crc_i;                // CRC that went out
                end
                RX_WAIT: begin
                    timeout_o <= !start_seen_i && tmo_hit;
                end
                RX_CHECK: begin
                    crc_o <= rx_crc_i;
                    if (crc_match) begin
                        done_o    <= 1'b1;
                        rd_data_o <= rx_word_i;
                    end else begin
                        crc_err_o <= 1'b1;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// File: design/sd_dat_rx.sv
// SD DAT receive path
// Collects data nibbles into a word and DAT0 bits into the received CRC
module sd_dat_rx (
    input  logic                PCLK_i,
    input  logic                PRESETn_i,
    input  sd_data_pkg::dat_t   dat_i,
    input  logic                data_en_i,
    input  logic                crc_en_i,
    output logic                start_seen_o,
    output sd_data_pkg::word_t  word_o,
    output sd_data_pkg::crc16_t rx_crc_o
);
    import sd_data_pkg::*;

    // Any line pulled low marks the start nibble
    assign start_seen_o = (dat_i != DAT_IDLE);

    // ==========================================================
    // Capture registers
    // ==========================================================
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            word_o   <= '0;
            rx_crc_o <= '0;
        end else begin
            // Data nibbles arrive MSB first
            if (data_en_i) begin
                word_o <= {word_o[27:0], dat_i};
            end

            // CRC is serial on DAT0 only
            if (crc_en_i) begin
                rx_crc_o <= {rx_crc_o[14:0], dat_i[0]};
            end
        end
    end

endmodule

// File: design/sd_dat_tx.sv
// SD DAT transmit path
// Shifts the word and the CRC onto the four DAT lines through a registered output
module sd_dat_tx (
    input  logic                     PCLK_i,
    input  logic                     PRESETn_i,
    input  logic                     load_i,
    input  sd_data_pkg::word_t       word_i,
    input  sd_data_pkg::crc16_t      crc_i,
    input  sd_data_pkg::data_state_t phase_i,
    input  logic                     shift_i,
    output sd_data_pkg::dat_t        nibble_o,
    output sd_data_pkg::dat_t        dat_o,
    output logic                     dat_oe_o
);
    import sd_data_pkg::*;

    word_t  word_q;       // Nibbles still to send, next one on top
    crc16_t crc_q;        // Remaining CRC bits
    logic   crc_run_q;    // CRC already latched in this phase

    // Next data nibble goes to the CRC unit as well
    assign nibble_o = word_q[31:28];

    // ==========================================================
    // Payload shift registers
    // ==========================================================
    always_ff @(posedge PCLK_i) begin
        if (load_i) begin
            word_q <= word_i;
        end else if (shift_i && (phase_i == TX_DATA)) begin
            word_q <= {word_q[27:0], 4'h0};
        end

        if (shift_i && (phase_i == TX_CRC)) begin
            if (crc_run_q) begin
                crc_q <= {crc_q[14:0], 1'b0};
            end else begin
                crc_q <= {crc_i[14:0], 1'b0};   // Latch on phase entry
            end
        end
    end

    // ==========================================================
    // Bus output register
    // ==========================================================
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            dat_o     <= DAT_IDLE;
            dat_oe_o  <= 1'b0;
            crc_run_q <= 1'b0;
        end else begin
            crc_run_q <= (phase_i == TX_CRC);
            case (phase_i)
                TX_START: begin
                    dat_o    <= 4'h0;               // Start nibble
                    dat_oe_o <= 1'b1;
                end
                TX_DATA: begin
                    if (shift_i) begin
                        dat_o <= nibble_o;
                    end
                    dat_oe_o <= 1'b1;
                end
                TX_CRC: begin
                    // CRC serial on DAT0 with the upper lines held high
                    if (shift_i) begin
                        dat_o <= {3'b111, (crc_run_q ? crc_q[15] : crc_i[15])};
                    end
                    dat_oe_o <= 1'b1;
                end
                TX_END: begin
                    dat_o    <= DAT_IDLE;           // End nibble
                    dat_oe_o <= 1'b1;
                end
                default: begin
                    dat_o    <= DAT_IDLE;
                    dat_oe_o <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: design/sd_crc16.sv
// CRC-16 accumulator for the DAT path
// Advances the 0x1021 LFSR by one nibble per enabled cycle, bit 3 first
module sd_crc16 (
    input  logic                PCLK_i,
    input  logic                PRESETn_i,
    input  logic                clear_i,
    input  logic                enable_i,
    input  sd_data_pkg::dat_t   nibble_i,
    output sd_data_pkg::crc16_t crc_o
);
    import sd_data_pkg::*;

    crc16_t crc_next;

    // Single serial step of the LFSR
    function automatic crc16_t crc_bit(input crc16_t crc, input logic din);
        logic fb;
        fb = crc[15] ^ din;
        return {crc[14:0], 1'b0} ^ (fb ? CRC16_POLY : 16'h0000);
    endfunction

    // Four serial steps per nibble, MSB of the nibble first
    always_comb begin
        crc_next = crc_o;
        for (int i = 3; i >= 0; i--) begin
            crc_next = crc_bit(crc_next, nibble_i[i]);
        end
    end

    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            crc_o <= '0;
        end else if (clear_i) begin
            crc_o <= '0;        // Initial value is zero
        end else if (enable_i) begin
            crc_o <= crc_next;
        end
    end

endmodule

// File: design/sd_data_pkg.sv
// SD card DAT path shared definitions
// Bus widths, controller states and timing constants
package sd_data_pkg;

    // ==========================================================
    // Vector types
    // ==========================================================
    typedef logic [3:0]  dat_t;        // One nibble of the DAT bus
    typedef logic [31:0] word_t;       // Data word of a transfer
    typedef logic [15:0] crc16_t;
    typedef logic [4:0]  phase_cnt_t;  // Position within a phase

    // Transfer states
    typedef enum logic [3:0] {
        IDLE     = 4'd0,
        TX_START = 4'd1,
        TX_DATA  = 4'd2,
        TX_CRC   = 4'd3,
        TX_END   = 4'd4,
        RX_WAIT  = 4'd5,
        RX_DATA  = 4'd6,
        RX_CRC   = 4'd7,
        RX_CHECK = 4'd8
    } data_state_t;

    // ==========================================================
    // Constants
    // ==========================================================
    localparam int     NIBBLES_PER_WORD = 8;
    localparam int     CRC_BITS         = 16;
    localparam crc16_t CRC16_POLY       = 16'h1021;  // x^16 + x^12 + x^5 + 1

    // PCLK cycles a read waits for the start nibble
    localparam int     TIMEOUT_LIMIT    = 64;
    localparam int     TIMEOUT_W        = $clog2(TIMEOUT_LIMIT);

    localparam dat_t   DAT_IDLE         = 4'hF;  // Idle bus and end nibble

endpackage
